// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/bus_pkg.sv
      - src/mmio_pkg.sv
      - src/memory_interface.sv
      - src/memory_map_controller.sv
      - src/word_ram.sv
      - src/timer_regs.sv
      - src/mem_subsystem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_mem_subsystem.sv

// File: src/bus_pkg.sv
package bus_pkg;

    // load/store request from the core
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask; // one bit per data bit
    } data_req_t;

    // command on the memory side of the arbiter
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } mem_cmd_t;

    // bits set in wmask take the new data
    function automatic logic [31:0] masked_merge(
        input logic [31:0] old_data,
        input logic [31:0] new_data,
        input logic [31:0] wmask
    );
        return (old_data & ~wmask) | (new_data & wmask);
    endfunction

endpackage

// File: src/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// ram geometry
`define MEM_WORDS        1024
`define MEM_READ_LATENCY 2

// word aligned address map
`define RAM_BASE         32'h0000_0000
`define MTIMECMP_BASE    32'h0200_4000 // low word first
`define MTIME_BASE       32'h0200_bff8 // read only view

// read value for holes in the map
`define UNMAPPED_DATA    32'hffff_ffff

`endif

// File: src/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               exited,
    input  logic [63:0]        mtime,
    output logic [63:0]        mtimecmp,

    input  logic               inst_start,
    output logic               inst_ready,
    input  logic [31:0]        i_addr,
    output logic [31:0]        inst,
    output logic               inst_valid,

    input  logic               d_cmd_start,
    output logic               d_cmd_ready,
    input  bus_pkg::data_req_t d_req,
    output logic [31:0]        rdata,
    output logic               rdata_valid
);

    import bus_pkg::*;
    import mmio_pkg::*;

    // arbiter to map controller
    logic        mem_cmd_start;
    mem_cmd_t    mem_cmd;
    logic        mem_cmd_ready;
    logic [31:0] mem_rdata;
    logic        mem_rdata_valid;

    // map controller to targets
    logic        ram_start;
    mem_cmd_t    ram_cmd;
    logic        ram_ready;
    logic [31:0] ram_rdata;
    logic        ram_rvalid;
    logic        tmr_start;
    region_t     tmr_region;
    logic [31:0] tmr_wdata;
    logic [31:0] tmr_wmask;
    logic [31:0] tmr_rdata;
    logic        tmr_rvalid;

    memory_interface memory_interface_inst (
        .clk             (clk),
        .reset           (reset),
        .exited          (exited),
        .inst_start      (inst_start),
        .inst_ready      (inst_ready),
        .i_addr          (i_addr),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .d_cmd_start     (d_cmd_start),
        .d_cmd_ready     (d_cmd_ready),
        .d_req           (d_req),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd         (mem_cmd),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    memory_map_controller memory_map_controller_inst (
        .clk             (clk),
        .reset           (reset),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd         (mem_cmd),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .ram_start       (ram_start),
        .ram_cmd         (ram_cmd),
        .ram_ready       (ram_ready),
        .ram_rdata       (ram_rdata),
        .ram_rvalid      (ram_rvalid),
        .tmr_start       (tmr_start),
        .tmr_region      (tmr_region),
        .tmr_wdata       (tmr_wdata),
        .tmr_wmask       (tmr_wmask),
        .tmr_rdata       (tmr_rdata),
        .tmr_rvalid      (tmr_rvalid)
    );

    word_ram word_ram_inst (
        .clk        (clk),
        .reset      (reset),
        .ram_start  (ram_start),
        .ram_cmd    (ram_cmd),
        .ram_ready  (ram_ready),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid)
    );

    timer_regs timer_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .tmr_start  (tmr_start),
        .tmr_region (tmr_region),
        .tmr_wdata  (tmr_wdata),
        .tmr_wmask  (tmr_wmask),
        .mtime      (mtime),
        .tmr_rdata  (tmr_rdata),
        .tmr_rvalid (tmr_rvalid),
        .mtimecmp   (mtimecmp)
    );

endmodule

// File: src/memory_interface.sv
`timescale 1ns/1ns

module memory_interface (
    input  logic               clk,
    input  logic               reset,
    input  logic               exited,

    input  logic               inst_start,
    output logic               inst_ready,
    input  logic [31:0]        i_addr,
    output logic [31:0]        inst,
    output logic               inst_valid,

    input  logic               d_cmd_start,
    output logic               d_cmd_ready,
    input  bus_pkg::data_req_t d_req,
    output logic [31:0]        rdata,
    output logic               rdata_valid,

    output logic               mem_cmd_start,
    output bus_pkg::mem_cmd_t  mem_cmd,
    input  logic               mem_cmd_ready,
    input  logic [31:0]        mem_rdata,
    input  logic               mem_rdata_valid
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        WAIT_CMD,
        WAIT_READY,
        WAIT_READ
    } state_t;

    state_t      state;
    logic        cmd_is_inst; // outstanding read is the fetch
    logic        pend_data;   // data request saved next to the fetch
    logic [31:0] save_i_addr;
    data_req_t   save_req;
    logic [31:0] inst_q;
    logic [31:0] rdata_q;

    logic        take;
    logic        fetch_done;
    logic        load_done;

    function automatic mem_cmd_t fetch_cmd(input logic [31:0] addr);
        mem_cmd_t cmd;
        cmd       = '0;
        cmd.addr  = addr;
        return cmd;
    endfunction

    assign take       = !exited && state == WAIT_CMD && (inst_start || d_cmd_start);
    assign fetch_done = !exited && state == WAIT_READ && mem_rdata_valid && cmd_is_inst;
    assign load_done  = !exited && state == WAIT_READ && mem_rdata_valid && !cmd_is_inst;

    assign inst_ready  = !exited && state == WAIT_CMD;
    assign d_cmd_ready = !exited && state == WAIT_CMD;

    assign inst_valid  = fetch_done;
    assign rdata_valid = load_done;
    assign inst        = fetch_done ? mem_rdata : inst_q; // hold between pulses
    assign rdata       = load_done ? mem_rdata : rdata_q;

    always_comb begin
        mem_cmd_start = 1'b0;
        mem_cmd       = mem_cmd_t'(save_req);
        case (state)
            WAIT_CMD: begin
                mem_cmd       = inst_start ? fetch_cmd(i_addr) : mem_cmd_t'(d_req); // fetch wins
                mem_cmd_start = take && mem_cmd_ready;
            end
            WAIT_READY: begin
                mem_cmd       = cmd_is_inst ? fetch_cmd(save_i_addr) : mem_cmd_t'(save_req);
                mem_cmd_start = !exited && mem_cmd_ready;
            end
            WAIT_READ: begin
                // chain the saved data command onto the returning fetch
                mem_cmd_start = fetch_done && pend_data && mem_cmd_ready;
            end
            default: begin
                mem_cmd_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= WAIT_CMD;
            cmd_is_inst <= 1'b0;
            pend_data   <= 1'b0;
        end else if (!exited) begin
            case (state)
                WAIT_CMD: begin
                    if (take) begin
                        cmd_is_inst <= inst_start;
                        pend_data   <= d_cmd_start;
                        if (!mem_cmd_ready)
                            state <= WAIT_READY;
                        else if (inst_start || !d_req.write)
                            state <= WAIT_READ; // stores finish at acceptance
                    end
                end
                WAIT_READY: begin
                    if (mem_cmd_ready)
                        state <= (cmd_is_inst || !save_req.write) ? WAIT_READ : WAIT_CMD;
                end
                WAIT_READ: begin
                    if (fetch_done) begin
                        if (pend_data) begin
                            cmd_is_inst <= 1'b0;
                            if (!mem_cmd_ready)
                                state <= WAIT_READY;
                            else if (save_req.write)
                                state <= WAIT_CMD;
                        end else begin
                            state <= WAIT_CMD;
                        end
                    end else if (load_done) begin
                        state <= WAIT_CMD;
                    end
                end
                default: state <= WAIT_CMD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            save_i_addr <= i_addr;
            save_req    <= d_req;
        end
        if (fetch_done)
            inst_q <= mem_rdata;
        if (load_done)
            rdata_q <= mem_rdata;
    end

endmodule

// File: src/memory_map_controller.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module memory_map_controller (
    input  logic              clk,
    input  logic              reset,

    input  logic              mem_cmd_start,
    input  bus_pkg::mem_cmd_t mem_cmd,
    output logic              mem_cmd_ready,
    output logic [31:0]       mem_rdata,
    output logic              mem_rdata_valid,

    output logic              ram_start,
    output bus_pkg::mem_cmd_t ram_cmd,
    input  logic              ram_ready,
    input  logic [31:0]       ram_rdata,
    input  logic              ram_rvalid,

    output logic              tmr_start,
    output mmio_pkg::region_t tmr_region,
    output logic [31:0]       tmr_wdata,
    output logic [31:0]       tmr_wmask,
    input  logic [31:0]       tmr_rdata,
    input  logic              tmr_rvalid
);

    import bus_pkg::*;
    import mmio_pkg::*;

    localparam logic [31:0] RAM_END = `RAM_BASE + 32'(`MEM_WORDS * 4);

    logic [31:0] word_addr;
    region_t     region;
    logic        accepted;
    logic        tmr_read_q;  // timer answer belongs to a load
    logic        none_read_q; // unmapped load answered next cycle

    assign word_addr = {mem_cmd.addr[31:2], 2'b00}; // low bits ignored

    always_comb begin
        if (word_addr >= `RAM_BASE && word_addr < RAM_END)
            region = REGION_RAM;
        else if (word_addr == `MTIMECMP_BASE)
            region = REGION_MTIMECMP_LO;
        else if (word_addr == `MTIMECMP_BASE + 32'd4)
            region = REGION_MTIMECMP_HI;
        else if (word_addr == `MTIME_BASE)
            region = REGION_MTIME_LO;
        else if (word_addr == `MTIME_BASE + 32'd4)
            region = REGION_MTIME_HI;
        else
            region = REGION_NONE;
    end

    assign mem_cmd_ready = ram_ready; // timer and holes never stall
    assign accepted      = mem_cmd_start && mem_cmd_ready;

    assign ram_start    = accepted && region == REGION_RAM;
    assign ram_cmd      = '{
        write: mem_cmd.write,
        addr:  word_addr - `RAM_BASE,
        wdata: mem_cmd.wdata,
        wmask: mem_cmd.wmask
    };

    assign tmr_start  = accepted && region != REGION_RAM && region != REGION_NONE;
    assign tmr_region = region;
    assign tmr_wdata  = mem_cmd.wdata;
    assign tmr_wmask  = mem_cmd.write ? mem_cmd.wmask : 32'h0; // zero mask leaves regs alone

    always_ff @(posedge clk) begin
        if (reset) begin
            tmr_read_q  <= 1'b0;
            none_read_q <= 1'b0;
        end else begin
            tmr_read_q  <= tmr_start && !mem_cmd.write;
            none_read_q <= accepted && region == REGION_NONE && !mem_cmd.write;
        end
    end

    // only one read is ever outstanding, so the sources never collide
    assign mem_rdata_valid = ram_rvalid || (tmr_rvalid && tmr_read_q) || none_read_q;
    assign mem_rdata       = ram_rvalid ? ram_rdata :
                             tmr_read_q ? tmr_rdata : `UNMAPPED_DATA;

endmodule

// File: src/mmio_pkg.sv
package mmio_pkg;

    // targets behind the map controller
    typedef enum logic [2:0] {
        REGION_RAM         = 3'd0,
        REGION_MTIMECMP_LO = 3'd1,
        REGION_MTIMECMP_HI = 3'd2,
        REGION_MTIME_LO    = 3'd3,
        REGION_MTIME_HI    = 3'd4,
        REGION_NONE        = 3'd7 // unmapped
    } region_t;

endpackage

// File: src/timer_regs.sv
`timescale 1ns/1ns

module timer_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              tmr_start,
    input  mmio_pkg::region_t tmr_region,
    input  logic [31:0]       tmr_wdata,
    input  logic [31:0]       tmr_wmask,
    input  logic [63:0]       mtime,
    output logic [31:0]       tmr_rdata,
    output logic              tmr_rvalid,
    output logic [63:0]       mtimecmp
);

    import bus_pkg::*;
    import mmio_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp   <= '1; // no interrupt until programmed
            tmr_rvalid <= 1'b0;
        end else begin
            tmr_rvalid <= tmr_start;
            if (tmr_start) begin
                case (tmr_region)
                    REGION_MTIMECMP_LO:
                        mtimecmp[31:0] <= masked_merge(mtimecmp[31:0], tmr_wdata, tmr_wmask);
                    REGION_MTIMECMP_HI:
                        mtimecmp[63:32] <= masked_merge(mtimecmp[63:32], tmr_wdata, tmr_wmask);
                    default: ; // mtime is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tmr_start) begin
            case (tmr_region)
                REGION_MTIMECMP_LO: tmr_rdata <= mtimecmp[31:0];
                REGION_MTIMECMP_HI: tmr_rdata <= mtimecmp[63:32];
                REGION_MTIME_LO:    tmr_rdata <= mtime[31:0];
                REGION_MTIME_HI:    tmr_rdata <= mtime[63:32];
                default:            tmr_rdata <= '0;
            endcase
        end
    end

endmodule

// File: src/word_ram.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module word_ram (
    input  logic              clk,
    input  logic              reset,
    input  logic              ram_start,
    input  bus_pkg::mem_cmd_t ram_cmd,
    output logic              ram_ready,
    output logic [31:0]       ram_rdata,
    output logic              ram_rvalid
);

    import bus_pkg::*;

    localparam int WORDS   = `MEM_WORDS;
    localparam int LATENCY = `MEM_READ_LATENCY;
    localparam int IDX_W   = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic [LATENCY-1:0] rd_valid;
    logic [31:0]      rd_data [LATENCY];
    logic             busy;

    assign idx = ram_cmd.addr[IDX_W+1:2]; // wraps modulo WORDS

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WORDS; i++)
                mem[i] <= '0; // ram comes up cleared
        end else if (ram_start && ram_cmd.write) begin
            mem[idx] <= masked_merge(mem[idx], ram_cmd.wdata, ram_cmd.wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            rd_valid <= '0;
        else
            rd_valid <= {rd_valid[LATENCY-2:0], ram_start && !ram_cmd.write};
    end

    always_ff @(posedge clk) begin
        rd_data[0] <= mem[idx];
        for (int i = 1; i < LATENCY; i++)
            rd_data[i] <= rd_data[i-1];
    end

    // last stage is free to take a new read as it drains
    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < LATENCY - 1; i++)
            busy = busy | rd_valid[i];
    end

    assign ram_ready  = !busy;
    assign ram_rvalid = rd_valid[LATENCY-1];
    assign ram_rdata  = rd_data[LATENCY-1];

endmodule

// File: tb.f
+incdir+src
src/bus_pkg.sv
src/mmio_pkg.sv
src/memory_interface.sv
src/memory_map_controller.sv
src/word_ram.sv
src/timer_regs.sv
src/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

// File: test/tb_mem_subsystem.sv
`timescale 1ns/1ns

`include "mem_consts.svh"

module tb_mem_subsystem;

    import bus_pkg::*;

    localparam int          RESET_CYCLES = 10;
    localparam logic [63:0] MTIME_VAL    = 64'h0123_4567_89ab_cdef;

    typedef enum logic [2:0] {
        OP_FETCH,
        OP_LOAD,
        OP_STORE,
        OP_BOTH,   // fetch and load in the same cycle
        OP_FREEZE  // exited window followed by a load
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] i_addr;
        logic [31:0] d_addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
        logic [31:0] exp_inst;
        logic [31:0] exp_data;
        logic [63:0] exp_cmp; // mtimecmp after the row
    } row_t;

    logic        clk;
    logic        reset;
    logic        exited;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        inst_start;
    logic        inst_ready;
    logic [31:0] i_addr;
    logic [31:0] inst;
    logic        inst_valid;
    logic        d_cmd_start;
    logic        d_cmd_ready;
    data_req_t   d_req;
    logic [31:0] rdata;
    logic        rdata_valid;

    row_t        rows[$];
    logic [31:0] shadow_mem [`MEM_WORDS];
    logic [63:0] shadow_cmp;
    logic [31:0] lcg_state = 32'hb7ac_95d4;
    int          exp_loads;
    int          load_pulses;
    bit          table_built;

    mem_subsystem_top mem_subsystem_top_inst (
        .clk         (clk),
        .reset       (reset),
        .exited      (exited),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_ready (d_cmd_ready),
        .d_req       (d_req),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] apply_mask(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [31:0] mask);
        logic [31:0] merged;
        for (int b = 0; b < 32; b++)
            merged[b] = mask[b] ? new_word[b] : old_word[b]; // set mask bit takes the new bit
        return merged;
    endfunction

    // expected view of the address map
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (a < `MEM_WORDS * 4)
            return shadow_mem[a >> 2];
        else if (a == `MTIMECMP_BASE)
            return shadow_cmp[31:0];
        else if (a == `MTIMECMP_BASE + 4)
            return shadow_cmp[63:32];
        else if (a == `MTIME_BASE)
            return MTIME_VAL[31:0];
        else if (a == `MTIME_BASE + 4)
            return MTIME_VAL[63:32];
        return `UNMAPPED_DATA;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] mask);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (a < `MEM_WORDS * 4)
            shadow_mem[a >> 2] = apply_mask(shadow_mem[a >> 2], data, mask);
        else if (a == `MTIMECMP_BASE)
            shadow_cmp[31:0] = apply_mask(shadow_cmp[31:0], data, mask);
        else if (a == `MTIMECMP_BASE + 4)
            shadow_cmp[63:32] = apply_mask(shadow_cmp[63:32], data, mask);
    endtask

    task automatic add_row(input op_t op, input logic [31:0] ia, input logic [31:0] da,
                           input logic [31:0] wd, input logic [31:0] wm);
        row_t r;
        r.op       = op;
        r.i_addr   = ia;
        r.d_addr   = da;
        r.wdata    = wd;
        r.wmask    = wm;
        r.exp_inst = model_read(ia);
        r.exp_data = (op == OP_STORE) ? 32'h0 : model_read(da);
        if (op == OP_STORE)
            model_write(da, wd, wm);
        if (op == OP_LOAD || op == OP_BOTH || op == OP_FREEZE)
            exp_loads++;
        r.exp_cmp  = shadow_cmp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] ram_addrs [8];
        logic [31:0] tmp;
        for (int i = 0; i < `MEM_WORDS; i++)
            shadow_mem[i] = '0;
        shadow_cmp = '1;
        for (int i = 0; i < 8; i++) begin
            tmp          = lcg_next();
            ram_addrs[i] = {20'h0, tmp[9:0], 2'b00};
            add_row(OP_STORE, 0, ram_addrs[i], lcg_next(), lcg_next());
        end
        for (int i = 0; i < 4; i++)   // second masked write on top
            add_row(OP_STORE, 0, ram_addrs[i], lcg_next(), lcg_next());
        for (int i = 0; i < 8; i++)
            add_row(OP_LOAD, 0, ram_addrs[i], 0, 0);
        add_row(OP_FETCH, ram_addrs[2], 0, 0, 0);
        add_row(OP_FETCH, ram_addrs[5], 0, 0, 0);
        for (int i = 0; i < 3; i++)
            add_row(OP_BOTH, ram_addrs[i], ram_addrs[7 - i], 0, 0);
        // partial masks on both timer compare halves
        add_row(OP_STORE, 0, `MTIMECMP_BASE, 32'h1234_5678, 32'h0000_ffff);
        add_row(OP_STORE, 0, `MTIMECMP_BASE + 4, 32'hcafe_babe, 32'hff00_ff00);
        add_row(OP_LOAD, 0, `MTIMECMP_BASE, 0, 0);
        add_row(OP_LOAD, 0, `MTIMECMP_BASE + 4, 0, 0);
        add_row(OP_LOAD, 0, `MTIME_BASE, 0, 0);
        add_row(OP_LOAD, 0, `MTIME_BASE + 4, 0, 0);
        add_row(OP_STORE, 0, `MTIME_BASE, 32'h0, 32'hffff_ffff);
        add_row(OP_LOAD, 0, `MTIME_BASE, 0, 0);
        // holes in the map plus one just past the ram that would alias on wrap
        add_row(OP_LOAD, 0, 32'h1000_0000, 0, 0);
        add_row(OP_FETCH, 32'h0300_0000, 0, 0, 0);
        add_row(OP_STORE, 0, `MEM_WORDS * 4 + ram_addrs[0], ~ram_addrs[0], 32'hffff_ffff);
        add_row(OP_LOAD, 0, ram_addrs[0], 0, 0);
        add_row(OP_FREEZE, 0, ram_addrs[1], 0, 0);
        table_built = 1'b1;
    endtask

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_equal(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        assert (act === exp) else begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic wait_until_ready();
        @(posedge clk);
        while (!(inst_ready && d_cmd_ready))
            @(posedge clk);
    endtask

    task automatic collect_inst(input logic [31:0] exp);
        do begin
            @(posedge clk);
            assert (!rdata_valid) else begin
                $display("load data returned before the fetch at %0t", $time);
                stop_with_failure();
            end
        end while (!inst_valid);
        expect_equal("inst", exp, inst);
    endtask

    task automatic collect_data(input logic [31:0] exp);
        do @(posedge clk); while (!rdata_valid);
        expect_equal("rdata", exp, rdata);
        @(posedge clk);
        expect_equal("rdata_valid", 0, rdata_valid); // one pulse per load
    endtask

    task automatic hold_frozen();
        wait_until_ready();
        exited <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            expect_equal("inst_ready", 0, inst_ready);
            expect_equal("d_cmd_ready", 0, d_cmd_ready);
            expect_equal("inst_valid", 0, inst_valid);
            expect_equal("rdata_valid", 0, rdata_valid);
        end
        exited <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        if (r.op == OP_FREEZE)
            hold_frozen();
        wait_until_ready();
        inst_start    <= (r.op == OP_FETCH || r.op == OP_BOTH);
        d_cmd_start   <= (r.op != OP_FETCH);
        i_addr        <= r.i_addr;
        d_req.write   <= (r.op == OP_STORE);
        d_req.addr    <= r.d_addr;
        d_req.wdata   <= r.wdata;
        d_req.wmask   <= r.wmask;
        @(posedge clk);
        inst_start    <= 1'b0;
        d_cmd_start   <= 1'b0;
        case (r.op)
            OP_STORE: begin
                do @(posedge clk); while (!d_cmd_ready);
            end
            OP_FETCH: collect_inst(r.exp_inst);
            OP_BOTH: begin
                collect_inst(r.exp_inst);
                collect_data(r.exp_data);
            end
            default: collect_data(r.exp_data);
        endcase
        expect_equal("mtimecmp", r.exp_cmp, mtimecmp);
    endtask

    always @(posedge clk) begin
        if (!reset && rdata_valid)
            load_pulses <= load_pulses + 1;
    end

    initial begin
        wait (table_built);
        repeat (rows.size() * 20 + RESET_CYCLES) @(posedge clk);
        $display("timeout: the stimulus table did not finish in time");
        stop_with_failure();
    end

    initial begin
        reset       = 1'b1;
        exited      = 1'b0;
        mtime       = MTIME_VAL; // held fixed so mtime reads are known
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_req       = '0;
        load_pulses = 0;
        exp_loads   = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        expect_equal("mtimecmp", 64'hffff_ffff_ffff_ffff, mtimecmp);
        foreach (rows[n])
            run_row(rows[n]);
        repeat (4) @(posedge clk);
        expect_equal("load pulse count", exp_loads, load_pulses);
        $display("TB PASSED");
        $finish;
    end

endmodule
